//--- design/core_pkg.sv
package core_pkg;

	// Reorder-buffer tag width used when the top level is not overridden
	localparam int TAG_WIDTH_DEFAULT = 5;

	// Whether an operand slot of a station entry already holds its value
	typedef enum logic {
		OPD_WAIT  = 1'b0,  // Waiting for its tag on the CDB
		OPD_READY = 1'b1   // Value captured
	} opd_state_t;

endpackage

//--- design/fpu_pkg.sv
package fpu_pkg;

	typedef enum logic {
		OP_FADD = 1'b0,
		OP_FSUB = 1'b1
	} fp_op_t;

	// IEEE 754 single precision fields
	localparam int EXP_WIDTH = 8;
	localparam int MAN_WIDTH = 23;
	localparam int EXP_BIAS  = 127;

endpackage

//--- design/fadd_fsub_rs.sv
`timescale 1ns/100ps

module fadd_fsub_rs #(
	parameter int TAG_WIDTH = 1,
	parameter int N_ENTRY   = 2
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 issue_valid,
	output logic                 issue_ready,
	input  fpu_pkg::fp_op_t      issue_op,
	input  logic [TAG_WIDTH-1:0] issue_tag,
	input  logic                 src_ready_0,
	input  logic [TAG_WIDTH-1:0] src_tag_0,
	input  logic [31:0]          src_data_0,
	input  logic                 src_ready_1,
	input  logic [TAG_WIDTH-1:0] src_tag_1,
	input  logic [31:0]          src_data_1,
	output logic                 disp_valid,
	input  logic                 disp_ready,
	output fpu_pkg::fp_op_t      disp_op,
	output logic [TAG_WIDTH-1:0] disp_tag,
	output logic [31:0]          disp_a,
	output logic [31:0]          disp_b,
	input  logic                 cdb_valid,
	input  logic [TAG_WIDTH-1:0] cdb_tag,
	input  logic [31:0]          cdb_data
);
	localparam int IDX_W = $clog2(N_ENTRY);

	// Entry 0 is always the oldest
	logic                   e_valid   [N_ENTRY];
	logic [TAG_WIDTH-1:0]   e_tag     [N_ENTRY];
	fpu_pkg::fp_op_t        e_op      [N_ENTRY];
	core_pkg::opd_state_t   e_state   [N_ENTRY][2];
	logic [TAG_WIDTH-1:0]   e_src_tag [N_ENTRY][2];
	logic [31:0]            e_data    [N_ENTRY][2];

	core_pkg::opd_state_t   upd_state [N_ENTRY][2];  // After CDB wakeup
	logic [31:0]            upd_data  [N_ENTRY][2];

	logic                   nxt_valid   [N_ENTRY];
	logic [TAG_WIDTH-1:0]   nxt_tag     [N_ENTRY];
	fpu_pkg::fp_op_t        nxt_op      [N_ENTRY];
	core_pkg::opd_state_t   nxt_state   [N_ENTRY][2];
	logic [TAG_WIDTH-1:0]   nxt_src_tag [N_ENTRY][2];
	logic [31:0]            nxt_data    [N_ENTRY][2];

	logic                   in_ready [2];
	logic [TAG_WIDTH-1:0]   in_tag   [2];
	logic [31:0]            in_data  [2];
	core_pkg::opd_state_t   new_state [2];
	logic [31:0]            new_data  [2];

	logic [IDX_W-1:0] sel;
	logic             dispatch;
	logic             issue_fire;

	assign in_ready[0] = src_ready_0;
	assign in_tag[0]   = src_tag_0;
	assign in_data[0]  = src_data_0;
	assign in_ready[1] = src_ready_1;
	assign in_tag[1]   = src_tag_1;
	assign in_data[1]  = src_data_1;

	always_comb begin
		for (int j = 0; j < 2; j++) begin
			if (in_ready[j]) begin
				new_state[j] = core_pkg::OPD_READY;
				new_data[j]  = in_data[j];
			end else if (cdb_valid && cdb_tag == in_tag[j]) begin  // Bypass in the issue cycle
				new_state[j] = core_pkg::OPD_READY;
				new_data[j]  = cdb_data;
			end else begin
				new_state[j] = core_pkg::OPD_WAIT;
				new_data[j]  = in_data[j];
			end
		end
	end

	always_comb begin
		for (int i = 0; i < N_ENTRY; i++) begin
			for (int j = 0; j < 2; j++) begin
				if (e_state[i][j] == core_pkg::OPD_WAIT && cdb_valid
						&& cdb_tag == e_src_tag[i][j]) begin
					upd_state[i][j] = core_pkg::OPD_READY;
					upd_data[i][j]  = cdb_data;
				end else begin
					upd_state[i][j] = e_state[i][j];
					upd_data[i][j]  = e_data[i][j];
				end
			end
		end
	end

	// Lowest ready index wins, so scan from the top down
	always_comb begin
		sel        = '0;
		disp_valid = 1'b0;
		for (int i = N_ENTRY - 1; i >= 0; i--) begin
			if (e_valid[i] && e_state[i][0] == core_pkg::OPD_READY
					&& e_state[i][1] == core_pkg::OPD_READY) begin
				sel        = IDX_W'(i);
				disp_valid = 1'b1;
			end
		end
	end

	assign disp_op  = e_op[sel];
	assign disp_tag = e_tag[sel];
	assign disp_a   = e_data[sel][0];
	assign disp_b   = e_data[sel][1];

	assign dispatch    = disp_valid && disp_ready;
	assign issue_ready = !e_valid[N_ENTRY-1] || dispatch;
	assign issue_fire  = issue_valid && issue_ready;

	always_comb begin
		int  src;
		logic placed;
		placed = 1'b0;
		for (int i = 0; i < N_ENTRY; i++) begin
			src = i;
			if (dispatch && i >= int'(sel) && i < N_ENTRY - 1)
				src = i + 1;  // Close the gap left by the dispatched entry
			nxt_valid[i] = e_valid[src] && !(dispatch && i >= int'(sel) && i == N_ENTRY - 1);
			nxt_tag[i]   = e_tag[src];
			nxt_op[i]    = e_op[src];
			for (int j = 0; j < 2; j++) begin
				nxt_state[i][j]   = upd_state[src][j];
				nxt_src_tag[i][j] = e_src_tag[src][j];
				nxt_data[i][j]    = upd_data[src][j];
			end
		end
		for (int i = 0; i < N_ENTRY; i++) begin
			if (issue_fire && !placed && !nxt_valid[i]) begin  // First free place
				placed       = 1'b1;
				nxt_valid[i] = 1'b1;
				nxt_tag[i]   = issue_tag;
				nxt_op[i]    = issue_op;
				for (int j = 0; j < 2; j++) begin
					nxt_state[i][j]   = new_state[j];
					nxt_src_tag[i][j] = in_tag[j];
					nxt_data[i][j]    = new_data[j];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < N_ENTRY; i++)
				e_valid[i] <= 1'b0;
		end else begin
			e_valid <= nxt_valid;
		end
	end

	always_ff @(posedge clk) begin
		e_tag     <= nxt_tag;
		e_op      <= nxt_op;
		e_state   <= nxt_state;
		e_src_tag <= nxt_src_tag;
		e_data    <= nxt_data;
	end

endmodule

//--- design/fp_addsub_pipe.sv
`timescale 1ns/100ps

module fp_addsub_pipe #(
	parameter int TAG_WIDTH = 1
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 disp_valid,
	output logic                 disp_ready,
	input  fpu_pkg::fp_op_t      disp_op,
	input  logic [TAG_WIDTH-1:0] disp_tag,
	input  logic [31:0]          disp_a,
	input  logic [31:0]          disp_b,
	output logic                 res_valid,
	input  logic                 res_ready,
	output logic [TAG_WIDTH-1:0] res_tag,
	output logic [31:0]          res_data
);
	localparam int EW = fpu_pkg::EXP_WIDTH;
	localparam int MW = fpu_pkg::MAN_WIDTH;
	localparam int SW = MW + 1;       // Significand with hidden bit
	localparam int AW = SW + 3;       // Plus guard, round and sticky
	localparam int XW = SW + AW - 1;  // Alignment window

	logic stall;
	logic adv;

	// Stage one, align
	logic          b_sign;
	logic          a_big;
	logic          big_sign;
	logic [EW-1:0] big_exp;
	logic [EW-1:0] diff;
	logic [MW-1:0] big_man;
	logic [MW-1:0] small_man;
	logic [XW-1:0] small_shifted;
	logic [AW-1:0] small_aligned;

	logic                 s1_valid;
	logic [TAG_WIDTH-1:0] s1_tag;
	logic                 s1_sign;
	logic                 s1_sub;
	logic [EW-1:0]        s1_exp;
	logic [AW-1:0]        s1_big;
	logic [AW-1:0]        s1_small;

	// Stage two, add
	logic                 s2_valid;
	logic [TAG_WIDTH-1:0] s2_tag;
	logic                 s2_sign;
	logic [EW-1:0]        s2_exp;
	logic [AW:0]          s2_sum;

	// Stage three, normalize
	int          lz;
	int          exp_unb;
	logic [AW:0] norm;
	logic [31:0] result;

	assign stall      = res_valid && !res_ready;
	assign adv        = !stall;
	assign disp_ready = adv;

	always_comb begin
		b_sign    = disp_b[EW+MW] ^ (disp_op == fpu_pkg::OP_FSUB);
		a_big     = disp_a[EW+MW-1:0] >= disp_b[EW+MW-1:0];
		big_sign  = a_big ? disp_a[EW+MW] : b_sign;
		big_exp   = a_big ? disp_a[EW+MW-1:MW] : disp_b[EW+MW-1:MW];
		diff      = a_big ? disp_a[EW+MW-1:MW] - disp_b[EW+MW-1:MW]
		                  : disp_b[EW+MW-1:MW] - disp_a[EW+MW-1:MW];
		big_man   = a_big ? disp_a[MW-1:0] : disp_b[MW-1:0];
		small_man = a_big ? disp_b[MW-1:0] : disp_a[MW-1:0];
		small_shifted = {1'b1, small_man, {(AW-1){1'b0}}} >> diff;
		if (diff > EW'(AW - 1))
			small_aligned = AW'(1);  // Whole significand below round, sticky only
		else
			small_aligned = {small_shifted[XW-1:SW], |small_shifted[SW-1:0]};
	end

	always_ff @(posedge clk) begin
		if (adv) begin
			s1_tag   <= disp_tag;
			s1_sign  <= big_sign;
			s1_sub   <= disp_a[EW+MW] ^ b_sign;
			s1_exp   <= big_exp;
			s1_big   <= {1'b1, big_man, 3'b000};
			s1_small <= small_aligned;
			s2_tag   <= s1_tag;
			s2_sign  <= s1_sign;
			s2_exp   <= s1_exp;
			s2_sum   <= s1_sub ? {1'b0, s1_big} - {1'b0, s1_small}
			                   : {1'b0, s1_big} + {1'b0, s1_small};
			res_tag  <= s2_tag;
			res_data <= result;
		end
	end

	always_comb begin
		logic found;
		found = 1'b0;
		lz    = 0;
		for (int i = AW; i >= 0; i--) begin
			if (!found && s2_sum[i]) begin
				found = 1'b1;
				lz    = AW - i;
			end
		end
		norm    = s2_sum << lz;
		exp_unb = int'(s2_exp) - fpu_pkg::EXP_BIAS + 1 - lz;
		if (!found || exp_unb < 1 - fpu_pkg::EXP_BIAS)
			result = '0;  // Cancellation or underflow gives +0
		else
			result = {s2_sign, EW'(exp_unb + fpu_pkg::EXP_BIAS), norm[AW-1 -: MW]};
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			s1_valid  <= 1'b0;
			s2_valid  <= 1'b0;
			res_valid <= 1'b0;
		end else if (adv) begin
			s1_valid  <= disp_valid;
			s2_valid  <= s1_valid;
			res_valid <= s2_valid;
		end
	end

endmodule

//--- design/cdb_arbiter.sv
`timescale 1ns/100ps

module cdb_arbiter #(
	parameter int TAG_WIDTH = 1
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 res_valid,
	output logic                 res_ready,
	input  logic [TAG_WIDTH-1:0] res_tag,
	input  logic [31:0]          res_data,
	input  logic                 ext_valid,
	output logic                 ext_ready,
	input  logic [TAG_WIDTH-1:0] ext_tag,
	input  logic [31:0]          ext_data,
	output logic                 cdb_valid,
	output logic [TAG_WIDTH-1:0] cdb_tag,
	output logic [31:0]          cdb_data
);
	logic last_ext;  // Outside producer won the last grant

	assign res_ready = res_valid && (!ext_valid || last_ext);
	assign ext_ready = ext_valid && (!res_valid || !last_ext);

	always_ff @(posedge clk) begin
		if (reset) begin
			last_ext  <= 1'b0;
			cdb_valid <= 1'b0;
		end else begin
			cdb_valid <= res_ready || ext_ready;
			if (res_ready || ext_ready)
				last_ext <= ext_ready;
		end
	end

	always_ff @(posedge clk) begin
		if (ext_ready) begin
			cdb_tag  <= ext_tag;
			cdb_data <= ext_data;
		end else if (res_ready) begin
			cdb_tag  <= res_tag;
			cdb_data <= res_data;
		end
	end

endmodule

//--- design/fp_cluster.sv
`timescale 1ns/100ps

module fp_cluster #(
	parameter int TAG_WIDTH = core_pkg::TAG_WIDTH_DEFAULT,
	parameter int N_ENTRY   = 2
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 issue_valid,
	output logic                 issue_ready,
	input  fpu_pkg::fp_op_t      issue_op,
	input  logic [TAG_WIDTH-1:0] issue_tag,
	input  logic                 src_ready_0,
	input  logic [TAG_WIDTH-1:0] src_tag_0,
	input  logic [31:0]          src_data_0,
	input  logic                 src_ready_1,
	input  logic [TAG_WIDTH-1:0] src_tag_1,
	input  logic [31:0]          src_data_1,
	input  logic                 ext_valid,
	output logic                 ext_ready,
	input  logic [TAG_WIDTH-1:0] ext_tag,
	input  logic [31:0]          ext_data,
	output logic                 cdb_valid,
	output logic [TAG_WIDTH-1:0] cdb_tag,
	output logic [31:0]          cdb_data
);
	logic                 disp_valid;
	logic                 disp_ready;
	fpu_pkg::fp_op_t      disp_op;
	logic [TAG_WIDTH-1:0] disp_tag;
	logic [31:0]          disp_a;
	logic [31:0]          disp_b;
	logic                 res_valid;
	logic                 res_ready;
	logic [TAG_WIDTH-1:0] res_tag;
	logic [31:0]          res_data;

	fadd_fsub_rs #(
		.TAG_WIDTH(TAG_WIDTH),
		.N_ENTRY  (N_ENTRY)
	) i_rs (
		.clk, .reset,
		.issue_valid, .issue_ready, .issue_op, .issue_tag,
		.src_ready_0, .src_tag_0, .src_data_0,
		.src_ready_1, .src_tag_1, .src_data_1,
		.disp_valid, .disp_ready, .disp_op, .disp_tag, .disp_a, .disp_b,
		.cdb_valid, .cdb_tag, .cdb_data  // Wakeup from the broadcast
	);

	fp_addsub_pipe #(
		.TAG_WIDTH(TAG_WIDTH)
	) i_pipe (
		.clk, .reset,
		.disp_valid, .disp_ready, .disp_op, .disp_tag, .disp_a, .disp_b,
		.res_valid, .res_ready, .res_tag, .res_data
	);

	cdb_arbiter #(
		.TAG_WIDTH(TAG_WIDTH)
	) i_arb (
		.clk, .reset,
		.res_valid, .res_ready, .res_tag, .res_data,
		.ext_valid, .ext_ready, .ext_tag, .ext_data,
		.cdb_valid, .cdb_tag, .cdb_data
	);

endmodule

//--- tb/fp_cluster_sva.sv
`timescale 1ns/100ps

module fp_cluster_sva #(
	parameter int TAG_WIDTH = 5
) (
	input logic                 clk,
	input logic                 reset,
	input logic                 res_valid,
	input logic                 res_ready,
	input logic [TAG_WIDTH-1:0] res_tag,
	input logic [31:0]          res_data,
	input logic                 ext_ready,
	input logic                 cdb_valid
);

	a_cdb_after_reset: assert property (@(posedge clk) reset |=> !cdb_valid)
		else $error("cdb_valid high in the cycle after reset");

	// Result must hold while the arbiter refuses it
	a_res_stable: assert property (@(posedge clk) disable iff (reset)
		res_valid && !res_ready |=> $stable(res_tag) && $stable(res_data))
		else $error("res_tag or res_data changed during a stall");

	a_grant_onehot: assert property (@(posedge clk) disable iff (reset)
		!(res_ready && ext_ready))
		else $error("res_ready and ext_ready granted together");

endmodule

bind fp_cluster fp_cluster_sva #(.TAG_WIDTH(TAG_WIDTH)) i_sva (
	.clk(clk), .reset(reset), .res_valid(res_valid), .res_ready(res_ready),
	.res_tag(res_tag), .res_data(res_data), .ext_ready(ext_ready), .cdb_valid(cdb_valid)
);

//--- tb/fp_cluster_tb.sv
`timescale 1ns/100ps

module fp_cluster_tb;
	localparam int TW     = core_pkg::TAG_WIDTH_DEFAULT;
	localparam int N_TAG  = 1 << TW;
	localparam int N_OPS  = 70;  // Operations issued into the station
	localparam int OP_TAGS = 24;  // Tags 24 and up belong to the outside producer

	logic clk, reset;
	logic issue_valid, issue_ready;
	fpu_pkg::fp_op_t issue_op;
	logic [TW-1:0] issue_tag, src_tag_0, src_tag_1, ext_tag, cdb_tag;
	logic src_ready_0, src_ready_1, ext_valid, ext_ready, cdb_valid;
	logic [31:0] src_data_0, src_data_1, ext_data, cdb_data;

	logic [31:0] exp_val [N_TAG];
	logic [31:0] done_val [N_TAG];
	logic        outstanding [N_TAG];
	int          done_cyc [N_TAG];
	string       tag_test [N_TAG];
	int cyc, pending, errors, checks, next_tag, last_tag, mon_tag;
	logic [31:0] seed;

	fp_cluster #(.TAG_WIDTH(TW), .N_ENTRY(2)) i_dut (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] lcg();
		seed = seed * 32'd1103515245 + 32'd12345;
		return seed;
	endfunction

	function automatic logic [31:0] rand_fp();
		logic [31:0] r;
		r = lcg();
		return {r[31], 8'(100 + (lcg() % 51)), r[22:0]};  // Exponents 100 to 150
	endfunction

	// Exact sum on significands scaled to the smaller exponent, then truncated
	function automatic logic [31:0] ref_addsub(logic [31:0] a, logic [31:0] b,
			fpu_pkg::fp_op_t op);
		logic sa, sb, sr;
		int ea, eb, emin, p, e;
		logic [127:0] ma, mb, mag, man;
		sa   = a[31];
		sb   = b[31] ^ (op == fpu_pkg::OP_FSUB);
		ea   = int'(a[30:23]);
		eb   = int'(b[30:23]);
		emin = (ea < eb) ? ea : eb;
		ma   = 128'({1'b1, a[22:0]}) << (ea - emin);
		mb   = 128'({1'b1, b[22:0]}) << (eb - emin);
		if (sa == sb) begin
			mag = ma + mb;
			sr  = sa;
		end else if (ma >= mb) begin
			mag = ma - mb;
			sr  = sa;
		end else begin
			mag = mb - ma;
			sr  = sb;
		end
		if (mag == 0)
			return 32'h0;
		p = 0;
		for (int i = 0; i < 128; i++)
			if (mag[i])
				p = i;
		e = p + emin - fpu_pkg::MAN_WIDTH;  // Biased exponent of the leading one
		if (e < 1)
			return 32'h0;
		man = (p >= fpu_pkg::MAN_WIDTH) ? mag >> (p - fpu_pkg::MAN_WIDTH)
		                                : mag << (fpu_pkg::MAN_WIDTH - p);
		return {sr, e[7:0], man[22:0]};
	endfunction

	task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			$display("MISMATCH %s expected %h actual %h", name, expected, actual);
			errors++;
		end
	endtask

	// A waiting operand whose producer already finished is sent as ready
	task automatic issue(string name, fpu_pkg::fp_op_t op, int tag,
			logic w0, int t0, logic [31:0] v0, logic w1, int t1, logic [31:0] v1,
			output int fire);
		logic [31:0] a, b;
		logic done;
		a = w0 ? exp_val[t0] : v0;
		b = w1 ? exp_val[t1] : v1;
		exp_val[tag]     = ref_addsub(a, b, op);
		tag_test[tag]    = name;
		outstanding[tag] = 1'b1;
		pending++;
		issue_valid = 1'b1;
		issue_op    = op;
		issue_tag   = TW'(tag);
		src_tag_0   = TW'(t0);
		src_tag_1   = TW'(t1);
		done = 1'b0;
		while (!done) begin
			src_ready_0 = !w0 || !outstanding[t0];
			src_data_0  = w0 ? done_val[t0] : v0;
			src_ready_1 = !w1 || !outstanding[t1];
			src_data_1  = w1 ? done_val[t1] : v1;
			@(negedge clk);
			if (issue_ready)
				done = 1'b1;
			else begin
				@(posedge clk);
				#1;
			end
		end
		fire = cyc;  // Cycle in which the issue handshake takes place
		@(posedge clk);
		#1 issue_valid = 1'b0;
	endtask

	task automatic expect_ext(string name, int tag, logic [31:0] v);
		exp_val[tag]     = v;
		tag_test[tag]    = name;
		outstanding[tag] = 1'b1;
		pending++;
	endtask

	task automatic push_ext(int tag, logic [31:0] v);
		ext_valid = 1'b1;
		ext_tag   = TW'(tag);
		ext_data  = v;
		@(negedge clk);
		while (!ext_ready)
			@(negedge clk);
		@(posedge clk);
		#1 ext_valid = 1'b0;
	endtask

	task automatic drain(string name);
		while (pending > 0) begin
			@(posedge clk);
			#1;
		end
		$display("Test %s finished, %0d errors so far", name, errors);
	endtask

	function automatic int alloc_tag();
		for (int k = 0; k < OP_TAGS; k++) begin
			if (!outstanding[(next_tag + k) % OP_TAGS]) begin
				next_tag = (next_tag + k + 1) % OP_TAGS;
				return (next_tag + OP_TAGS - 1) % OP_TAGS;
			end
		end
		return -1;
	endfunction

	always @(posedge clk)
		cyc <= cyc + 1;

	// Scoreboard compare on every broadcast
	always @(negedge clk) begin
		if (!reset && cdb_valid) begin
			mon_tag = int'(cdb_tag);
			if (!outstanding[mon_tag]) begin
				$display("Broadcast of tag %0d that was not outstanding", mon_tag);
				errors++;
			end else begin
				check_value(tag_test[mon_tag], exp_val[mon_tag], cdb_data);
				outstanding[mon_tag] = 1'b0;
				pending--;
			end
			done_val[mon_tag] = cdb_data;
			done_cyc[mon_tag] = cyc;
		end
	end

	initial begin
		repeat (40 * N_OPS + 200) @(posedge clk);
		$display("Timeout: not every result reached the CDB in time");
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		int f1, tg;
		logic [31:0] x, y;
		logic w0, w1;
		fpu_pkg::fp_op_t op;
		seed = 32'haac1;
		cyc = 0;
		pending = 0;
		errors = 0;
		checks = 0;
		next_tag = 0;
		last_tag = 0;
		for (int i = 0; i < N_TAG; i++) begin
			outstanding[i] = 1'b0;
			done_val[i]    = '0;
			done_cyc[i]    = 0;
		end
		reset = 1'b1;
		issue_valid = 1'b0;
		issue_op = fpu_pkg::OP_FADD;
		issue_tag = '0;
		src_ready_0 = 1'b0;
		src_tag_0 = '0;
		src_data_0 = '0;
		src_ready_1 = 1'b0;
		src_tag_1 = '0;
		src_data_1 = '0;
		ext_valid = 1'b0;
		ext_tag = '0;
		ext_data = '0;
		repeat (4) @(posedge clk);
		#1 reset = 1'b0;

		issue("fadd_ready", fpu_pkg::OP_FADD, 1, 0, 0, 32'h3fc00000, 0, 0, 32'h40200000, f1);
		drain("fadd_ready");
		check_value("fadd_latency", 32'd5, 32'(done_cyc[1] - f1));

		issue("fsub", fpu_pkg::OP_FSUB, 2, 0, 0, rand_fp(), 0, 0, rand_fp(), f1);
		x = rand_fp();
		issue("fsub_equal", fpu_pkg::OP_FSUB, 3, 0, 0, x, 0, 0, x, f1);
		drain("fsub");

		x = rand_fp();
		expect_ext("ext_source", 30, x);
		issue("ext_wakeup", fpu_pkg::OP_FADD, 4, 1, 30, '0, 0, 0, rand_fp(), f1);
		repeat (3) @(posedge clk);
		#1 push_ext(30, x);
		drain("ext_wakeup");

		issue("chain_first", fpu_pkg::OP_FADD, 5, 0, 0, rand_fp(), 0, 0, rand_fp(), f1);
		issue("chain_second", fpu_pkg::OP_FSUB, 6, 1, 5, '0, 0, 0, rand_fp(), f1);
		drain("chain");
		if (done_cyc[6] <= done_cyc[5]) begin
			$display("Chained result was broadcast before its producer");
			errors++;
		end

		fork
			for (int k = 0; k < 4; k++)
				issue("contention_rs", fpu_pkg::OP_FADD, 8 + k, 0, 0, rand_fp(), 0, 0,
				      rand_fp(), f1);
			begin
				repeat (4) @(posedge clk);
				#1;
				for (int k = 0; k < 6; k++) begin
					y = rand_fp();
					expect_ext("contention_ext", 24 + k, y);
					push_ext(24 + k, y);
				end
			end
		join
		drain("contention");

		for (int k = 0; k < 60; k++) begin
			op = lcg() % 2 ? fpu_pkg::OP_FSUB : fpu_pkg::OP_FADD;
			w0 = (lcg() % 4 == 0) && outstanding[last_tag];
			w1 = (lcg() % 4 == 0) && outstanding[last_tag];
			tg = alloc_tag();
			issue("random", op, tg, w0, last_tag, rand_fp(), w1, last_tag, rand_fp(), f1);
			last_tag = tg;
		end
		drain("random");

		$display("Checks run %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

//--- fp_cluster.f
design/core_pkg.sv
design/fpu_pkg.sv
design/fadd_fsub_rs.sv
design/fp_addsub_pipe.sv
design/cdb_arbiter.sv
design/fp_cluster.sv
tb/fp_cluster_sva.sv
tb/fp_cluster_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the fp_cluster testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wall -Wno-fatal \
	-f fp_cluster.f --top-module fp_cluster_tb -o sim_fp_cluster \
	> build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/sim_fp_cluster > sim.log 2>&1
cat sim.log

! grep -q "CHECKS FAILED" sim.log && grep -q "ALL CHECKS PASSED" sim.log \
	&& { echo "Simulation passed"; exit 0; } \
	|| { echo "Simulation failed"; exit 1; }
